// ==== project.f ====
hdl/lcd_pkg.sv
hdl/lcd_init_seq.sv
hdl/lcd_screen_text.sv
hdl/lcd_write_sched.sv
hdl/lcd_worldclock.sv
testbench/lcd_bus_checker.sv
testbench/lcd_worldclock_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module lcd_worldclock_tb -o lcd_sim &&
./obj_dir/lcd_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run_sim: passed" ||
{ echo "run_sim: failed"; exit 1; }

// ==== testbench/lcd_worldclock_tb.sv ====
`timescale 1ns/1ps

module lcd_worldclock_tb;

    localparam int FRAME_CYCLES = 2 * lcd_pkg::SLOTS_PER_LINE * lcd_pkg::CYCLES_PER_SLOT +
                                  lcd_pkg::WAIT_FRAME;
    localparam int INIT_CYCLES = 1 + lcd_pkg::WAIT_POWER_UP +
                                 (lcd_pkg::INIT_CMDS - 1) * lcd_pkg::WAIT_CMD;
    localparam int TEST_FRAMES = 12;
    localparam int TIMEOUT_CYCLES = INIT_CYCLES + (TEST_FRAMES + 2) * FRAME_CYCLES;

    logic               clk;
    logic               rst;
    logic               mode_12h;
    logic               is_pm;
    logic               alarm_mode;
    logic               alarm_en;
    lcd_pkg::tz_sel_t   tz_sel;
    logic               lcd_e;
    logic               lcd_rs;
    lcd_pkg::lcd_byte_t lcd_data;

    int error_count;
    int frame_count;
    int cycle_cnt = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int seed;
    lcd_pkg::tz_sel_t tz_order [4];

    lcd_worldclock lcd_worldclock_inst (
        .clk        (clk),
        .rst        (rst),
        .mode_12h   (mode_12h),
        .is_pm      (is_pm),
        .alarm_mode (alarm_mode),
        .alarm_en   (alarm_en),
        .tz_sel     (tz_sel),
        .lcd_e      (lcd_e),
        .lcd_rs     (lcd_rs),
        .lcd_data   (lcd_data)
    );

    lcd_bus_checker lcd_bus_checker_inst (
        .clk         (clk),
        .rst         (rst),
        .lcd_e       (lcd_e),
        .lcd_rs      (lcd_rs),
        .lcd_data    (lcd_data),
        .mode_12h    (mode_12h),
        .is_pm       (is_pm),
        .alarm_mode  (alarm_mode),
        .alarm_en    (alarm_en),
        .tz_sel      (tz_sel),
        .error_count (error_count),
        .frame_count (frame_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: frames stopped arriving, run ended after %0d cycles", cycle_cnt);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // fisher-yates over the four zones.
    task automatic shuffle_zones();
        int j;
        lcd_pkg::tz_sel_t tmp;
        for (int i = 0; i < 4; i++) tz_order[i] = lcd_pkg::tz_sel_t'(i);
        for (int i = 3; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            tmp = tz_order[i];
            tz_order[i] = tz_order[j];
            tz_order[j] = tmp;
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frame_count + n;
        while (frame_count < target) begin
            @(posedge clk);
        end
    endtask

    task automatic log_result(input string name, input int errs_before);
        tests_run = tests_run + 1;
        if (error_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: %0d errors", name, error_count - errs_before);
        end
    endtask

    // inputs held for two full frames.
    task automatic run_test(input string name, input logic m12, input logic pm,
                            input logic alarm, input logic en, input lcd_pkg::tz_sel_t tz);
        int errs_before;
        @(posedge clk);
        mode_12h   <= m12;
        is_pm      <= pm;
        alarm_mode <= alarm;
        alarm_en   <= en;
        tz_sel     <= tz;
        errs_before = error_count;
        wait_frames(2);
        log_result(name, errs_before);
    endtask

    initial begin
        int errs_before;
        seed       = 32'h4746_931d;
        rst        = 1'b1;
        mode_12h   = 1'b0;
        is_pm      = 1'b0;
        alarm_mode = 1'b0;
        alarm_en   = 1'b0;
        tz_sel     = lcd_pkg::TZ_KOREA;
        shuffle_zones();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        errs_before = error_count;
        wait_frames(1);
        log_result("init sequence", errs_before);
        run_test($sformatf("24-hour, zone %0d", tz_order[0]), 1'b0, 1'b0, 1'b0, 1'b0, tz_order[0]);
        run_test($sformatf("12-hour AM, zone %0d", tz_order[1]), 1'b1, 1'b0, 1'b0, 1'b0, tz_order[1]);
        run_test($sformatf("12-hour PM, zone %0d", tz_order[2]), 1'b1, 1'b1, 1'b0, 1'b0, tz_order[2]);
        run_test($sformatf("24-hour, zone %0d", tz_order[3]), 1'b0, 1'b1, 1'b0, 1'b0, tz_order[3]);
        run_test("alarm on", 1'b1, 1'b1, 1'b1, 1'b1, tz_order[0]);
        run_test("alarm off", 1'b0, 1'b0, 1'b1, 1'b0, tz_order[1]);
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/lcd_bus_checker.sv ====
`timescale 1ns/1ps

module lcd_bus_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               lcd_e,
    input  logic               lcd_rs,
    input  lcd_pkg::lcd_byte_t lcd_data,
    input  logic               mode_12h,
    input  logic               is_pm,
    input  logic               alarm_mode,
    input  logic               alarm_en,
    input  lcd_pkg::tz_sel_t   tz_sel,
    output int                 error_count,
    output int                 frame_count
);

    int decode_errs = 0;
    int pulse_errs = 0;
    int spacing_errs = 0;
    int hold_errs = 0;

    int gap;          // cycles since the previous write.
    int cmd_idx;
    int col;
    logic cur_line2;
    logic refresh;
    lcd_pkg::lcd_byte_t exp_char;

    // inputs as the dut saw them when it registered the write.
    logic mode_q, pm_q, alarm_q, en_q;
    lcd_pkg::tz_sel_t tz_q;

    assign error_count = decode_errs + pulse_errs + spacing_errs + hold_errs;

    function automatic lcd_pkg::lcd_byte_t init_cmd(input int idx);
        case (idx)
            0, 1:    return lcd_pkg::CMD_FUNC_SET;
            2:       return lcd_pkg::CMD_DISP_ON;
            3:       return lcd_pkg::CMD_ENTRY_MODE;
            default: return lcd_pkg::CMD_CLEAR;
        endcase
    endfunction

    function automatic int cmd_spacing(input int idx);
        if (idx == 0) return 1; // first edge after reset release.
        if (idx == 1) return lcd_pkg::WAIT_POWER_UP;
        return lcd_pkg::WAIT_CMD;
    endfunction

    function automatic string line_text(input logic l2, input logic m12, input logic pm,
                                        input logic alarm, input logic en,
                                        input lcd_pkg::tz_sel_t tz);
        if (alarm) begin
            if (!l2) return "ALARM SET MODE";
            return en ? "ALARM ON" : "ALARM OFF";
        end
        if (!l2) begin
            if (!m12) return "24hour mode";
            return pm ? "12hour mode PM" : "12hour mode AM";
        end
        case (tz)
            lcd_pkg::TZ_KOREA:    return "Korea time";
            lcd_pkg::TZ_PARIS:    return "Paris time";
            lcd_pkg::TZ_NEW_YORK: return "NewYork time";
            default:              return "UK time";
        endcase
    endfunction

    // slot numbers start at 1, spaces past the end.
    function automatic lcd_pkg::lcd_byte_t char_at(input string s, input int pos);
        if (pos > s.len()) return " ";
        return s[pos-1];
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            gap <= 0;
        end else if (lcd_e) begin
            gap <= 1;
        end else begin
            gap <= gap + 1;
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_idx     <= 0;
            col         <= 0;
            cur_line2   <= 1'b0;
            refresh     <= 1'b0;
            frame_count <= 0;
        end else if (lcd_e && !lcd_rs) begin
            if (!refresh && lcd_data == lcd_pkg::ADDR_LINE1) begin
                assert (cmd_idx == lcd_pkg::INIT_CMDS && gap == lcd_pkg::WAIT_CMD) else begin
                    $display("error %0t: first 80h after %0d cmds, gap %0d", $time, cmd_idx, gap);
                    decode_errs = decode_errs + 1;
                end
                refresh     <= 1'b1;
                cur_line2   <= 1'b0;
                col         <= 0;
                frame_count <= frame_count + 1;
            end else if (!refresh) begin
                assert (cmd_idx < lcd_pkg::INIT_CMDS && lcd_data == init_cmd(cmd_idx) &&
                        gap == cmd_spacing(cmd_idx)) else begin
                    $display("error %0t: init cmd %0d is %h after %0d cycles", $time, cmd_idx,
                             lcd_data, gap);
                    decode_errs = decode_errs + 1;
                end
                cmd_idx <= cmd_idx + 1;
            end else begin
                // line 1 ends in C0h, line 2 ends in the frame pause and 80h.
                assert ((lcd_data == lcd_pkg::ADDR_LINE2 && !cur_line2 ||
                         lcd_data == lcd_pkg::ADDR_LINE1 && cur_line2 &&
                         gap == lcd_pkg::CYCLES_PER_SLOT + lcd_pkg::WAIT_FRAME) &&
                        col == lcd_pkg::SLOTS_PER_LINE - 1) else begin
                    $display("error %0t: address %h after %0d chars, gap %0d", $time, lcd_data,
                             col, gap);
                    decode_errs = decode_errs + 1;
                end
                cur_line2 <= (lcd_data == lcd_pkg::ADDR_LINE2);
                col       <= 0;
                if (lcd_data == lcd_pkg::ADDR_LINE1) frame_count <= frame_count + 1;
            end
        end else if (lcd_e) begin
            exp_char = char_at(line_text(cur_line2, mode_q, pm_q, alarm_q, en_q, tz_q), col + 1);
            assert (refresh && col < lcd_pkg::SLOTS_PER_LINE - 1 && lcd_data == exp_char) else begin
                $display("error %0t: line %0d slot %0d got %h expected %h", $time,
                         cur_line2 + 1, col + 1, lcd_data, exp_char);
                decode_errs = decode_errs + 1;
            end
            col <= col + 1;
        end
    end

    always @(posedge clk) begin
        mode_q  <= mode_12h;
        pm_q    <= is_pm;
        alarm_q <= alarm_mode;
        en_q    <= alarm_en;
        tz_q    <= tz_sel;
    end

    a_e_pulse: assert property (@(posedge clk) disable iff (rst) lcd_e |=> !lcd_e)
        else begin
            $display("error %0t: lcd_e high for two cycles", $time);
            pulse_errs = pulse_errs + 1;
        end

    // characters and the line 2 address both follow the slot pitch.
    a_slot_pitch: assert property (@(posedge clk) disable iff (rst)
        (lcd_e && (lcd_rs || lcd_data == lcd_pkg::ADDR_LINE2)) |-> gap == lcd_pkg::CYCLES_PER_SLOT)
        else begin
            $display("error %0t: write %h after %0d cycles", $time, lcd_data, gap);
            spacing_errs = spacing_errs + 1;
        end

    a_bus_hold: assert property (@(posedge clk) disable iff (rst)
        !lcd_e |-> $stable(lcd_data) && $stable(lcd_rs))
        else begin
            $display("error %0t: bus changed without lcd_e", $time);
            hold_errs = hold_errs + 1;
        end

endmodule

// ==== hdl/lcd_worldclock.sv ====
`timescale 1ns/1ps

module lcd_worldclock (
    input  logic               clk,
    input  logic               rst,
    input  logic               mode_12h,
    input  logic               is_pm,
    input  logic               alarm_mode,
    input  logic               alarm_en,
    input  lcd_pkg::tz_sel_t   tz_sel,
    output logic               lcd_e,
    output logic               lcd_rs,
    output lcd_pkg::lcd_byte_t lcd_data
);

    logic               cmd_stb;
    logic               init_done;
    lcd_pkg::lcd_byte_t cmd_byte;
    lcd_pkg::lcd_byte_t char_byte;
    logic               line2;
    lcd_pkg::slot_t     slot;

    lcd_init_seq lcd_init_seq_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd_stb   (cmd_stb),
        .cmd_byte  (cmd_byte),
        .init_done (init_done)
    );

    lcd_write_sched lcd_write_sched_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd_stb   (cmd_stb),
        .init_done (init_done),
        .cmd_byte  (cmd_byte),
        .char_byte (char_byte),
        .line2     (line2),
        .slot      (slot),
        .lcd_e     (lcd_e),
        .lcd_rs    (lcd_rs),
        .lcd_data  (lcd_data)
    );

    // text lookup is combinational, sampled at each write slot.
    lcd_screen_text lcd_screen_text_inst (
        .line2      (line2),
        .mode_12h   (mode_12h),
        .is_pm      (is_pm),
        .alarm_mode (alarm_mode),
        .alarm_en   (alarm_en),
        .tz_sel     (tz_sel),
        .slot       (slot),
        .char_byte  (char_byte)
    );

endmodule

// ==== hdl/lcd_write_sched.sv ====
`timescale 1ns/1ps

module lcd_write_sched (
    input  logic               clk,
    input  logic               rst,
    input  logic               cmd_stb,
    input  logic               init_done,
    input  lcd_pkg::lcd_byte_t cmd_byte,
    input  lcd_pkg::lcd_byte_t char_byte,
    output logic               line2,
    output lcd_pkg::slot_t     slot,
    output logic               lcd_e,
    output logic               lcd_rs,
    output lcd_pkg::lcd_byte_t lcd_data
);

    localparam int SUB_W = $clog2(lcd_pkg::CYCLES_PER_SLOT);

    logic [SUB_W-1:0]   sub_cnt;   // clock within the current slot.
    logic               in_wait;   // pause between frames.
    lcd_pkg::wait_cnt_t frame_cnt;
    logic               slot_start;
    logic               slot_end;
    logic               line_end;

    assign slot_start = (sub_cnt == '0);
    assign slot_end   = (sub_cnt == SUB_W'(lcd_pkg::CYCLES_PER_SLOT - 1));
    assign line_end   = (slot == lcd_pkg::slot_t'(lcd_pkg::SLOTS_PER_LINE - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lcd_e     <= 1'b0;
            lcd_rs    <= 1'b0;
            lcd_data  <= '0;
            line2     <= 1'b0;
            slot      <= '0;
            sub_cnt   <= '0;
            in_wait   <= 1'b0;
            frame_cnt <= '0;
        end else begin
            lcd_e <= 1'b0;
            if (!init_done) begin
                // pass init commands straight through.
                if (cmd_stb) begin
                    lcd_e    <= 1'b1;
                    lcd_rs   <= 1'b0;
                    lcd_data <= cmd_byte;
                end
            end else if (in_wait) begin
                if (frame_cnt == lcd_pkg::wait_cnt_t'(lcd_pkg::WAIT_FRAME - 1)) begin
                    frame_cnt <= '0;
                    in_wait   <= 1'b0;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end else begin
                if (slot_start) begin
                    lcd_e <= 1'b1;
                    if (slot == '0) begin
                        lcd_rs   <= 1'b0; // ddram address.
                        lcd_data <= line2 ? lcd_pkg::ADDR_LINE2 : lcd_pkg::ADDR_LINE1;
                    end else begin
                        lcd_rs   <= 1'b1;
                        lcd_data <= char_byte;
                    end
                end
                if (slot_end) begin
                    sub_cnt <= '0;
                    if (line_end) begin
                        slot    <= '0;
                        line2   <= !line2;
                        in_wait <= line2; // frame ends after line 2.
                    end else begin
                        slot <= slot + 1'b1;
                    end
                end else begin
                    sub_cnt <= sub_cnt + 1'b1;
                end
            end
        end
    end

    // enable pulse is a single clock wide.
    a_e_single: assert property (
        @(posedge clk) disable iff (rst)
        lcd_e |=> !lcd_e
    );

    // a line address on the bus always goes out as a command.
    a_addr_cmd: assert property (
        @(posedge clk) disable iff (rst)
        (lcd_e && (lcd_data == lcd_pkg::ADDR_LINE1 || lcd_data == lcd_pkg::ADDR_LINE2)) |->
            !lcd_rs
    );

endmodule

// ==== hdl/lcd_screen_text.sv ====
`timescale 1ns/1ps

module lcd_screen_text (
    input  logic               line2,
    input  logic               mode_12h,
    input  logic               is_pm,
    input  logic               alarm_mode,
    input  logic               alarm_en,
    input  lcd_pkg::tz_sel_t   tz_sel,
    input  lcd_pkg::slot_t     slot,
    output lcd_pkg::lcd_byte_t char_byte
);

    always_comb begin
        char_byte = " "; // padding past the end of any text.
        if (alarm_mode) begin
            // both alarm screens start with "ALARM ".
            case (slot)
                4'd1: char_byte = "A";
                4'd2: char_byte = "L";
                4'd3: char_byte = "A";
                4'd4: char_byte = "R";
                4'd5: char_byte = "M";
                default: begin
                    if (!line2) begin
                        case (slot)
                            4'd7:  char_byte = "S";
                            4'd8:  char_byte = "E";
                            4'd9:  char_byte = "T";
                            4'd11: char_byte = "M";
                            4'd12: char_byte = "O";
                            4'd13: char_byte = "D";
                            4'd14: char_byte = "E";
                            default: char_byte = " ";
                        endcase
                    end else begin
                        case (slot)
                            4'd7:  char_byte = "O";
                            4'd8:  char_byte = alarm_en ? "N" : "F";
                            4'd9:  char_byte = alarm_en ? " " : "F";
                            default: char_byte = " ";
                        endcase
                    end
                end
            endcase
        end else if (!line2) begin
            case (slot)
                4'd1:  char_byte = mode_12h ? "1" : "2";
                4'd2:  char_byte = mode_12h ? "2" : "4";
                4'd3:  char_byte = "h";
                4'd4:  char_byte = "o";
                4'd5:  char_byte = "u";
                4'd6:  char_byte = "r";
                4'd8:  char_byte = "m";
                4'd9:  char_byte = "o";
                4'd10: char_byte = "d";
                4'd11: char_byte = "e";
                4'd13: char_byte = mode_12h ? (is_pm ? "P" : "A") : " "; // am/pm marker.
                4'd14: char_byte = mode_12h ? "M" : " ";
                default: char_byte = " ";
            endcase
        end else begin
            case (tz_sel)
                lcd_pkg::TZ_KOREA: begin
                    case (slot)
                        4'd1:  char_byte = "K";
                        4'd2:  char_byte = "o";
                        4'd3:  char_byte = "r";
                        4'd4:  char_byte = "e";
                        4'd5:  char_byte = "a";
                        4'd7:  char_byte = "t";
                        4'd8:  char_byte = "i";
                        4'd9:  char_byte = "m";
                        4'd10: char_byte = "e";
                        default: char_byte = " ";
                    endcase
                end
                lcd_pkg::TZ_PARIS: begin
                    case (slot)
                        4'd1:  char_byte = "P";
                        4'd2:  char_byte = "a";
                        4'd3:  char_byte = "r";
                        4'd4:  char_byte = "i";
                        4'd5:  char_byte = "s";
                        4'd7:  char_byte = "t";
                        4'd8:  char_byte = "i";
                        4'd9:  char_byte = "m";
                        4'd10: char_byte = "e";
                        default: char_byte = " ";
                    endcase
                end
                lcd_pkg::TZ_NEW_YORK: begin
                    case (slot)
                        4'd1:  char_byte = "N";
                        4'd2:  char_byte = "e";
                        4'd3:  char_byte = "w";
                        4'd4:  char_byte = "Y";
                        4'd5:  char_byte = "o";
                        4'd6:  char_byte = "r";
                        4'd7:  char_byte = "k";
                        4'd9:  char_byte = "t";
                        4'd10: char_byte = "i";
                        4'd11: char_byte = "m";
                        4'd12: char_byte = "e";
                        default: char_byte = " ";
                    endcase
                end
                default: begin
                    // uk.
                    case (slot)
                        4'd1:  char_byte = "U";
                        4'd2:  char_byte = "K";
                        4'd4:  char_byte = "t";
                        4'd5:  char_byte = "i";
                        4'd6:  char_byte = "m";
                        4'd7:  char_byte = "e";
                        default: char_byte = " ";
                    endcase
                end
            endcase
        end
    end

endmodule

// ==== hdl/lcd_init_seq.sv ====
`timescale 1ns/1ps

module lcd_init_seq (
    input  logic              clk,
    input  logic              rst,
    output logic              cmd_stb,
    output lcd_pkg::lcd_byte_t cmd_byte,
    output logic              init_done
);

    localparam int STEP_W = $clog2(lcd_pkg::INIT_CMDS);

    logic [STEP_W-1:0]   step;
    lcd_pkg::wait_cnt_t  wait_cnt;
    lcd_pkg::wait_cnt_t  step_last;
    logic                last_step;

    // first step carries the long power-up wait.
    assign step_last = (step == '0) ? lcd_pkg::wait_cnt_t'(lcd_pkg::WAIT_POWER_UP - 1)
                                    : lcd_pkg::wait_cnt_t'(lcd_pkg::WAIT_CMD - 1);
    assign last_step = (step == STEP_W'(lcd_pkg::INIT_CMDS - 1));

    // strobe at the start of each step, registered once in the scheduler.
    assign cmd_stb = (wait_cnt == '0);

    always_comb begin
        case (step)
            3'd0,
            3'd1:    cmd_byte = lcd_pkg::CMD_FUNC_SET; // sent twice.
            3'd2:    cmd_byte = lcd_pkg::CMD_DISP_ON;
            3'd3:    cmd_byte = lcd_pkg::CMD_ENTRY_MODE;
            default: cmd_byte = lcd_pkg::CMD_CLEAR;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step      <= '0;
            wait_cnt  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            if (wait_cnt == step_last) begin
                if (last_step) begin
                    init_done <= 1'b1; // sequencer idles from here.
                end else begin
                    step     <= step + 1'b1;
                    wait_cnt <= '0;
                end
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // once done, the sequencer stays quiet until the next reset.
    a_done_quiet: assert property (
        @(posedge clk) disable iff (rst)
        init_done |-> !cmd_stb
    );

endmodule

// ==== hdl/lcd_pkg.sv ====
package lcd_pkg;

    // one byte on the lcd data bus, command or character.
    typedef logic [7:0] lcd_byte_t;

    typedef enum logic [1:0] {
        TZ_KOREA    = 2'd0,
        TZ_PARIS    = 2'd1,
        TZ_NEW_YORK = 2'd2,
        TZ_UK       = 2'd3
    } tz_sel_t;

    // slot 0 is the line address, 1 to 15 are characters.
    typedef logic [3:0] slot_t;

    typedef logic [6:0] wait_cnt_t;

    // hd44780 command bytes.
    localparam lcd_byte_t CMD_FUNC_SET   = 8'h38; // 8 bit bus, 2 lines, 5x8.
    localparam lcd_byte_t CMD_DISP_ON    = 8'h0C; // display on, no cursor.
    localparam lcd_byte_t CMD_ENTRY_MODE = 8'h06; // increment, no shift.
    localparam lcd_byte_t CMD_CLEAR      = 8'h01;

    // ddram address commands.
    localparam lcd_byte_t ADDR_LINE1 = 8'h80;
    localparam lcd_byte_t ADDR_LINE2 = 8'hC0;

    // init step lengths in clocks.
    localparam int WAIT_POWER_UP = 71;
    localparam int WAIT_CMD      = 31;
    localparam int INIT_CMDS     = 5;

    // refresh geometry.
    localparam int CYCLES_PER_SLOT = 4;
    localparam int SLOTS_PER_LINE  = 16;
    localparam int WAIT_FRAME      = 11; // idle clocks between frames.

endpackage
